// ==== sim.f ====
common/tcdm_pkg.sv
hw/sub_group/tcdm_bank.sv
hw/sub_group/tcdm_req_decode.sv
hw/sub_group/tcdm_resp_route.sv
hw/sub_group/tcdm_sub_group.sv
dv/tcdm_sub_group_chk.sv
dv/tcdm_sub_group_tb.sv

// ==== dv/tcdm_sub_group_tb.sv ====
// Directed and random traffic on all four initiators against a word-array model.
// Needs a simulator with concurrent assertion and bind support.
`timescale 1ns/10ps

module tcdm_sub_group_tb;

  localparam int NumWords = tcdm_pkg::NumTiles * tcdm_pkg::RowsPerBank;
  localparam int NumInit  = tcdm_pkg::NumInit;
  localparam int RandLen  = 64;
  localparam int Rounds   = 8;
  localparam int TotalReq = 3 * NumWords + 2 + NumInit * (2 * RandLen + Rounds);
  localparam int WatchdogCycles = TotalReq * NumInit * 8;

  logic                   clk_i;
  logic                   rst_i;
  logic [NumInit-1:0]     req_valid_i;
  logic [NumInit-1:0]     req_ready_o;
  tcdm_pkg::addr_t [NumInit-1:0] req_addr_i;
  logic [NumInit-1:0]     req_wen_i;
  tcdm_pkg::data_t [NumInit-1:0] req_wdata_i;
  tcdm_pkg::strb_t [NumInit-1:0] req_be_i;
  logic [NumInit-1:0]     resp_valid_o;
  logic [NumInit-1:0]     resp_ready_i;
  tcdm_pkg::data_t [NumInit-1:0] resp_rdata_o;

  // Reference memory and expected responses per initiator
  tcdm_pkg::data_t model_mem [NumWords];
  tcdm_pkg::data_t exp_q [NumInit][$];

  // One request list per initiator
  tcdm_pkg::addr_t list_addr  [NumInit][tcdm_pkg::RowsPerBank];
  logic            list_wen   [NumInit][tcdm_pkg::RowsPerBank];
  tcdm_pkg::data_t list_wdata [NumInit][tcdm_pkg::RowsPerBank];
  tcdm_pkg::strb_t list_be    [NumInit][tcdm_pkg::RowsPerBank];
  int              list_len   [NumInit];

  logic [31:0] lfsr_state;
  int n_checks;
  int n_errors;
  int n_tests;
  int err_mark;
  int max_wait;

  tcdm_sub_group DUT (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_addr_i   (req_addr_i  ),
    .req_wen_i    (req_wen_i   ),
    .req_wdata_i  (req_wdata_i ),
    .req_be_i     (req_be_i    ),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------
  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Old word for a read and zero for a write
  // Enabled bytes of a write are merged into the model
  function tcdm_pkg::data_t exp_access(input tcdm_pkg::addr_t addr, input logic wen,
                                       input tcdm_pkg::data_t wdata, input tcdm_pkg::strb_t be);
    int w;
    w = int'(addr >> tcdm_pkg::ByteOffset);
    if (!wen) begin
      return model_mem[w];
    end
    for (int b = 0; b < tcdm_pkg::StrbWidth; b++) begin
      if (be[b]) begin
        model_mem[w][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return '0;
  endfunction

  function tcdm_pkg::data_t fill_word(input int w);
    logic [9:0] a;
    a = w[9:0];
    return {6'h2b, a, ~a, 6'h15};
  endfunction

  // Row low bits equal the id so initiators never share a word
  function tcdm_pkg::addr_t own_addr(input int id, input logic [31:0] tile);
    logic [31:0] hi;
    hi = rand_bits(6);
    return {hi[5:0], 2'(id), tile[1:0], 2'b00};
  endfunction

  function int pending();
    int n;
    n = 0;
    for (int i = 0; i < NumInit; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_rdata(input tcdm_pkg::data_t got, input tcdm_pkg::data_t exp,
                             input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Consumed responses against the expected queues
  always @(negedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < NumInit; i++) begin
        if (resp_valid_o[i] && resp_ready_i[i]) begin
          if (exp_q[i].size() == 0) begin
            n_errors++;
            $display("initiator %0d got a response with no request outstanding at %0t",
                     i, $time);
          end else begin
            check_rdata(resp_rdata_o[i], exp_q[i].pop_front(),
                        $sformatf("rdata of initiator %0d", i));
          end
        end
        if (resp_valid_o[i] && !resp_ready_i[i]) begin
          check_ready(req_ready_o[i], 1'b0, $sformatf("req_ready of stalled initiator %0d", i));
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic do_req(input int id, input tcdm_pkg::addr_t addr, input logic wen,
                        input tcdm_pkg::data_t wdata, input tcdm_pkg::strb_t be);
    int waited;
    waited = 0;
    req_addr_i[id]  = addr;
    req_wen_i[id]   = wen;
    req_wdata_i[id] = wdata;
    req_be_i[id]    = be;
    req_valid_i[id] = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o[id]) begin
      waited++;
      @(negedge clk_i);
    end
    if (waited > max_wait) begin
      n_errors++;
      $display("initiator %0d waited %0d cycles for a grant, more than %0d", id, waited,
               max_wait);
    end
    exp_q[id].push_back(exp_access(addr, wen, wdata, be));
    @(posedge clk_i);
    #1;
    req_valid_i[id] = 1'b0;
  endtask

  task automatic run_list(input int id);
    for (int k = 0; k < list_len[id]; k++) begin
      do_req(id, list_addr[id][k], list_wen[id][k], list_wdata[id][k], list_be[id][k]);
    end
  endtask

  task automatic run_all(input bit rand_ready);
    bit done;
    done = 1'b0;
    fork
      begin
        fork
          run_list(0);
          run_list(1);
          run_list(2);
          run_list(3);
        join
        done = 1'b1;
      end
      begin
        // End of traffic is seen at the falling edge only
        resp_ready_i = rand_ready ? NumInit'(rand_bits(NumInit)) : '1;
        @(negedge clk_i);
        while (!done) begin
          @(posedge clk_i);
          #1;
          resp_ready_i = rand_ready ? NumInit'(rand_bits(NumInit)) : '1;
          @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        resp_ready_i = '1;
      end
    join
  endtask

  task automatic build_sweep(input logic wen);
    int id;
    int k;
    for (int i = 0; i < NumInit; i++) begin
      list_len[i] = NumWords / NumInit;
    end
    for (int w = 0; w < NumWords; w++) begin
      id = w % NumInit;
      k  = w / NumInit;
      list_addr[id][k]  = tcdm_pkg::addr_t'(w << tcdm_pkg::ByteOffset);
      list_wen[id][k]   = wen;
      list_wdata[id][k] = fill_word(w);
      list_be[id][k]    = '1;
    end
  endtask

  task automatic build_lists(input int len, input bit same_tile);
    logic [31:0] tile;
    tile = rand_bits(2);
    for (int i = 0; i < NumInit; i++) begin
      list_len[i] = len;
      for (int k = 0; k < len; k++) begin
        list_addr[i][k]  = own_addr(i, same_tile ? tile : rand_bits(2));
        list_wen[i][k]   = 1'(rand_bits(1));
        list_wdata[i][k] = rand_bits(32);
        list_be[i][k]    = tcdm_pkg::strb_t'(rand_bits(4));
      end
    end
  endtask

  task automatic wait_idle();
    resp_ready_i = '1;
    @(negedge clk_i);
    while (resp_valid_o != '0 || pending() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %0d %s: %0d errors", n_tests, name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    tcdm_pkg::addr_t addr;
    tcdm_pkg::data_t wdata;
    lfsr_state   = 32'h34cd_46cf;
    n_checks     = 0;
    n_errors     = 0;
    n_tests      = 0;
    err_mark     = 0;
    max_wait     = NumInit - 1;
    rst_i        = 1'b1;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    @(negedge clk_i);
    for (int i = 0; i < NumInit; i++) begin
      check_valid(resp_valid_o[i], 1'b0, $sformatf("resp_valid %0d after reset", i));
    end
    @(posedge clk_i);
    #1;
    build_sweep(1'b1);
    run_all(1'b0);
    build_sweep(1'b0);
    run_all(1'b0);
    wait_idle();
    finish_test("reset and full sweep");

    // Partial write and read back with the response one cycle after acceptance
    addr  = tcdm_pkg::addr_t'(rand_bits(12));
    wdata = rand_bits(32);
    do_req(0, addr, 1'b1, wdata, 4'b0101);
    @(negedge clk_i);
    check_valid(resp_valid_o[0], 1'b1, "write response one cycle after acceptance");
    @(posedge clk_i);
    #1;
    do_req(0, addr, 1'b0, '0, '0);
    @(negedge clk_i);
    check_valid(resp_valid_o[0], 1'b1, "read response one cycle after acceptance");
    @(posedge clk_i);
    #1;
    wait_idle();
    finish_test("byte-enabled write and read");

    build_lists(RandLen, 1'b0);
    run_all(1'b0);
    wait_idle();
    finish_test("concurrent random traffic");

    repeat (Rounds) begin
      build_lists(1, 1'b1);
      run_all(1'b0);
    end
    wait_idle();
    finish_test("same-tile conflicts");

    max_wait = WatchdogCycles;
    build_lists(RandLen, 1'b0);
    run_all(1'b1);
    build_sweep(1'b0);
    run_all(1'b1);
    wait_idle();
    finish_test("response back-pressure and final sweep");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             n_tests, n_checks, n_errors, DUT.i_chk.fail_cnt);
    if (n_errors == 0 && DUT.i_chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== dv/tcdm_sub_group_chk.sv ====
// Handshake properties of the sub-group top level, bound into every instance.
// Assumes the top-level port names stay as they are.
`timescale 1ns/10ps

module tcdm_sub_group_chk (
  input logic                                      clk_i,
  input logic                                      rst_i,
  input logic              [tcdm_pkg::NumInit-1:0] req_ready_o,
  input logic              [tcdm_pkg::NumInit-1:0] resp_valid_o,
  input logic              [tcdm_pkg::NumInit-1:0] resp_ready_i,
  input tcdm_pkg::data_t   [tcdm_pkg::NumInit-1:0] resp_rdata_o
);

  int unsigned fail_cnt;

  initial fail_cnt = 0;

  for (genvar i = 0; i < tcdm_pkg::NumInit; i++) begin : gen_ini
    // Held response keeps valid and data until taken
    assert property (@(posedge clk_i) disable iff (rst_i)
      resp_valid_o[i] && !resp_ready_i[i] |=> resp_valid_o[i] && $stable(resp_rdata_o[i]))
    else begin
      fail_cnt++;
      $error("initiator %0d response changed before it was taken", i);
    end

    // No new grant while the previous response waits
    assert property (@(posedge clk_i) disable iff (rst_i)
      resp_valid_o[i] && !resp_ready_i[i] |-> !req_ready_o[i])
    else begin
      fail_cnt++;
      $error("initiator %0d got ready with a response still waiting", i);
    end
  end

  assert property (@(posedge clk_i) $fell(rst_i) |-> resp_valid_o == '0)
  else begin
    fail_cnt++;
    $error("response valid in the first cycle after reset");
  end

endmodule

bind tcdm_sub_group tcdm_sub_group_chk i_chk (.*);

// ==== hw/sub_group/tcdm_sub_group.sv ====
// Local TCDM interconnect of one sub-group: four initiators, four banks.
// Each initiator may have only one response outstanding at a time.
`timescale 1ns/10ps

module tcdm_sub_group (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Request channel
  input  logic              [tcdm_pkg::NumInit-1:0] req_valid_i,
  output logic              [tcdm_pkg::NumInit-1:0] req_ready_o,
  input  tcdm_pkg::addr_t   [tcdm_pkg::NumInit-1:0] req_addr_i,
  input  logic              [tcdm_pkg::NumInit-1:0] req_wen_i,
  input  tcdm_pkg::data_t   [tcdm_pkg::NumInit-1:0] req_wdata_i,
  input  tcdm_pkg::strb_t   [tcdm_pkg::NumInit-1:0] req_be_i,
  // Response channel
  output logic              [tcdm_pkg::NumInit-1:0] resp_valid_o,
  input  logic              [tcdm_pkg::NumInit-1:0] resp_ready_i,
  output tcdm_pkg::data_t   [tcdm_pkg::NumInit-1:0] resp_rdata_o
);

  // ------------------------------------------------------------
  // Decode to bank
  // ------------------------------------------------------------
  logic                [tcdm_pkg::NumTiles-1:0] bank_req;
  tcdm_pkg::row_t      [tcdm_pkg::NumTiles-1:0] bank_row;
  logic                [tcdm_pkg::NumTiles-1:0] bank_wen;
  tcdm_pkg::data_t     [tcdm_pkg::NumTiles-1:0] bank_wdata;
  tcdm_pkg::strb_t     [tcdm_pkg::NumTiles-1:0] bank_be;
  tcdm_pkg::ini_id_t   [tcdm_pkg::NumTiles-1:0] bank_ini;
  logic                [tcdm_pkg::NumTiles-1:0] bank_ready;

  // Bank to route, and back
  logic                [tcdm_pkg::NumTiles-1:0] bank_valid;
  tcdm_pkg::data_t     [tcdm_pkg::NumTiles-1:0] bank_rdata;
  tcdm_pkg::ini_id_t   [tcdm_pkg::NumTiles-1:0] bank_resp_ini;
  logic                [tcdm_pkg::NumTiles-1:0] drain;
  logic                [tcdm_pkg::NumInit-1:0]  init_free;

  tcdm_req_decode i_req_decode (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i ),
    .req_wen_i    (req_wen_i  ),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i   ),
    .init_free_i  (init_free  ),
    .bank_ready_i (bank_ready ),
    .req_ready_o  (req_ready_o),
    .bank_req_o   (bank_req   ),
    .bank_row_o   (bank_row   ),
    .bank_wen_o   (bank_wen   ),
    .bank_wdata_o (bank_wdata ),
    .bank_be_o    (bank_be    ),
    .bank_ini_o   (bank_ini   )
  );

  // ------------------------------------------------------------
  // One bank per tile
  // ------------------------------------------------------------
  for (genvar t = 0; t < tcdm_pkg::NumTiles; t++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i        (clk_i           ),
      .rst_i        (rst_i           ),
      .req_i        (bank_req[t]     ),
      .row_i        (bank_row[t]     ),
      .wen_i        (bank_wen[t]     ),
      .wdata_i      (bank_wdata[t]   ),
      .be_i         (bank_be[t]      ),
      .ini_i        (bank_ini[t]     ),
      .drain_i      (drain[t]        ),
      .ready_o      (bank_ready[t]   ),
      .resp_valid_o (bank_valid[t]   ),
      .resp_rdata_o (bank_rdata[t]   ),
      .resp_ini_o   (bank_resp_ini[t])
    );
  end

  tcdm_resp_route i_resp_route (
    .bank_valid_i (bank_valid   ),
    .bank_rdata_i (bank_rdata   ),
    .bank_ini_i   (bank_resp_ini),
    .resp_ready_i (resp_ready_i ),
    .resp_valid_o (resp_valid_o ),
    .resp_rdata_o (resp_rdata_o ),
    .init_free_o  (init_free    ),
    .drain_o      (drain        )
  );

endmodule

// ==== hw/sub_group/tcdm_resp_route.sv ====
// Combinational response routing from banks back to initiators by id.
// At most one bank holds a response per initiator at any time.
`timescale 1ns/10ps

module tcdm_resp_route (
  // Bank side
  input  logic              [tcdm_pkg::NumTiles-1:0] bank_valid_i,
  input  tcdm_pkg::data_t   [tcdm_pkg::NumTiles-1:0] bank_rdata_i,
  input  tcdm_pkg::ini_id_t [tcdm_pkg::NumTiles-1:0] bank_ini_i,
  output logic              [tcdm_pkg::NumTiles-1:0] drain_o,
  // Initiator side
  input  logic              [tcdm_pkg::NumInit-1:0]  resp_ready_i,
  output logic              [tcdm_pkg::NumInit-1:0]  resp_valid_o,
  output tcdm_pkg::data_t   [tcdm_pkg::NumInit-1:0]  resp_rdata_o,
  output logic              [tcdm_pkg::NumInit-1:0]  init_free_o
);

  // Bank t holds a response for initiator i
  logic [tcdm_pkg::NumInit-1:0][tcdm_pkg::NumTiles-1:0] hit;

  always_comb begin
    for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
      for (int t = 0; t < tcdm_pkg::NumTiles; t++) begin
        hit[i][t] = bank_valid_i[t] && (bank_ini_i[t] == i);
      end
    end
  end

  // ------------------------------------------------------------
  // Per-initiator select
  // ------------------------------------------------------------
  // AND-OR mux, the hit vector is one-hot or empty
  always_comb begin
    for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
      resp_valid_o[i] = |hit[i];
      resp_rdata_o[i] = '0;
      for (int t = 0; t < tcdm_pkg::NumTiles; t++) begin
        resp_rdata_o[i] |= bank_rdata_i[t] & {tcdm_pkg::DataWidth{hit[i][t]}};
      end
    end
  end

  // ------------------------------------------------------------
  // Drain and free status
  // ------------------------------------------------------------
  always_comb begin
    for (int t = 0; t < tcdm_pkg::NumTiles; t++) begin
      drain_o[t] = bank_valid_i[t] && resp_ready_i[bank_ini_i[t]];
    end
  end

  // Free when nothing is held, or the held response leaves this cycle
  assign init_free_o = ~resp_valid_o | resp_ready_i;

endmodule

// ==== hw/sub_group/tcdm_req_decode.sv ====
// Address split and per-bank round-robin arbitration.
// Pointer wrap relies on NumInit being a power of two.
`timescale 1ns/10ps

module tcdm_req_decode (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // Initiator side
  input  logic              [tcdm_pkg::NumInit-1:0] req_valid_i,
  input  tcdm_pkg::addr_t   [tcdm_pkg::NumInit-1:0] req_addr_i,
  input  logic              [tcdm_pkg::NumInit-1:0] req_wen_i,
  input  tcdm_pkg::data_t   [tcdm_pkg::NumInit-1:0] req_wdata_i,
  input  tcdm_pkg::strb_t   [tcdm_pkg::NumInit-1:0] req_be_i,
  input  logic              [tcdm_pkg::NumInit-1:0] init_free_i,
  output logic              [tcdm_pkg::NumInit-1:0] req_ready_o,
  // Bank side
  input  logic             [tcdm_pkg::NumTiles-1:0] bank_ready_i,
  output logic             [tcdm_pkg::NumTiles-1:0] bank_req_o,
  output tcdm_pkg::row_t   [tcdm_pkg::NumTiles-1:0] bank_row_o,
  output logic             [tcdm_pkg::NumTiles-1:0] bank_wen_o,
  output tcdm_pkg::data_t  [tcdm_pkg::NumTiles-1:0] bank_wdata_o,
  output tcdm_pkg::strb_t  [tcdm_pkg::NumTiles-1:0] bank_be_o,
  output tcdm_pkg::ini_id_t [tcdm_pkg::NumTiles-1:0] bank_ini_o
);

  tcdm_pkg::tile_idx_t [tcdm_pkg::NumInit-1:0] req_tile;
  tcdm_pkg::row_t      [tcdm_pkg::NumInit-1:0] req_row;

  // One-hot grant per bank, indexed by initiator
  logic [tcdm_pkg::NumTiles-1:0][tcdm_pkg::NumInit-1:0] grant;

  // ------------------------------------------------------------
  // Address split
  // ------------------------------------------------------------
  for (genvar i = 0; i < tcdm_pkg::NumInit; i++) begin : gen_split
    assign req_tile[i] = req_addr_i[i][tcdm_pkg::ByteOffset +: tcdm_pkg::TileBits];
    assign req_row[i]  = req_addr_i[i][tcdm_pkg::ByteOffset + tcdm_pkg::TileBits +:
                                       tcdm_pkg::RowBits];
  end

  // ------------------------------------------------------------
  // Per-bank arbitration
  // ------------------------------------------------------------
  for (genvar t = 0; t < tcdm_pkg::NumTiles; t++) begin : gen_arb
    logic              [tcdm_pkg::NumInit-1:0] elig;
    logic              [tcdm_pkg::NumInit-1:0] grant_vec;
    logic                                      found;
    tcdm_pkg::ini_id_t                         winner;
    tcdm_pkg::ini_id_t                         rr_q;

    // Valid, aimed at this bank, and no response pending elsewhere
    always_comb begin
      for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
        elig[i] = req_valid_i[i] && init_free_i[i] && (req_tile[i] == t);
      end
    end

    // First eligible initiator at or after the pointer
    always_comb begin
      tcdm_pkg::ini_id_t cand;
      found  = 1'b0;
      winner = rr_q;
      for (int k = 0; k < tcdm_pkg::NumInit; k++) begin
        cand = tcdm_pkg::ini_id_t'(rr_q + k);
        if (!found && elig[cand]) begin
          found  = 1'b1;
          winner = cand;
        end
      end
    end

    assign bank_req_o[t]   = found && bank_ready_i[t];
    assign bank_row_o[t]   = req_row[winner];
    assign bank_wen_o[t]   = req_wen_i[winner];
    assign bank_wdata_o[t] = req_wdata_i[winner];
    assign bank_be_o[t]    = req_be_i[winner];
    assign bank_ini_o[t]   = winner;

    always_comb begin
      grant_vec         = '0;
      grant_vec[winner] = bank_req_o[t];
    end

    assign grant[t] = grant_vec;

    // Next search starts just past the last winner
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rr_q <= '0;
      end else if (bank_req_o[t]) begin
        rr_q <= winner + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Ready back to the winners only
  // ------------------------------------------------------------
  always_comb begin
    req_ready_o = '0;
    for (int t = 0; t < tcdm_pkg::NumTiles; t++) begin
      req_ready_o |= grant[t];
    end
  end

endmodule

// ==== hw/sub_group/tcdm_bank.sv ====
// Single-port tile bank with a one-entry response register.
// The response is held until drained; a new grant is taken in the drain cycle.
`timescale 1ns/10ps

module tcdm_bank (
  input  logic              clk_i,
  input  logic              rst_i,
  // Grant from decode
  input  logic              req_i,
  input  tcdm_pkg::row_t    row_i,
  input  logic              wen_i,
  input  tcdm_pkg::data_t   wdata_i,
  input  tcdm_pkg::strb_t   be_i,
  input  tcdm_pkg::ini_id_t ini_i,
  output logic              ready_o,
  // Held response
  input  logic              drain_i,
  output logic              resp_valid_o,
  output tcdm_pkg::data_t   resp_rdata_o,
  output tcdm_pkg::ini_id_t resp_ini_o
);

  tcdm_pkg::data_t   mem_q [tcdm_pkg::RowsPerBank];
  logic              valid_q;
  tcdm_pkg::data_t   rdata_q;
  tcdm_pkg::ini_id_t ini_q;

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      for (int b = 0; b < tcdm_pkg::StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------
  // Old word on a read, zero on a write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= wen_i ? '0 : mem_q[row_i];
      ini_q   <= ini_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_i) begin
      valid_q <= 1'b1;
    end else if (drain_i) begin
      valid_q <= 1'b0;
    end
  end

  assign ready_o      = !valid_q || drain_i;
  assign resp_valid_o = valid_q;
  assign resp_rdata_o = rdata_q;
  assign resp_ini_o   = ini_q;

endmodule

// ==== common/tcdm_pkg.sv ====
// Sizes and vector types of the local sub-group interconnect.
// All counts must be powers of two; addresses are word interleaved
// across the tiles and the byte-offset bits are ignored.
package tcdm_pkg;

  // ------------------------------------------------------------
  // Sub-group sizes
  // ------------------------------------------------------------
  localparam int unsigned NumInit     = 4;
  localparam int unsigned NumTiles    = 4;
  localparam int unsigned RowsPerBank = 256;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned ByteOffset  = 2;

  // Derived field widths
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned TileBits  = $clog2(NumTiles);
  localparam int unsigned RowBits   = $clog2(RowsPerBank);
  localparam int unsigned IniBits   = $clog2(NumInit);
  localparam int unsigned AddrWidth = RowBits + TileBits + ByteOffset;

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------
  // Read or write data word
  typedef logic [DataWidth-1:0] data_t;

  // Byte enables, one per data byte
  typedef logic [StrbWidth-1:0] strb_t;

  // Byte address as row | tile | byte offset
  typedef logic [AddrWidth-1:0] addr_t;

  // Target bank
  typedef logic [TileBits-1:0] tile_idx_t;

  // Word row inside a bank
  typedef logic [RowBits-1:0] row_t;

  // Initiator id, travels with the request and back with the response
  typedef logic [IniBits-1:0] ini_id_t;

endpackage
